// File: rgmii_rx.f
src/rgmii_rx_pkg.sv
src/ddr_input_buffer.sv
src/rgmii_byte_packager.sv
src/rx_crc_checker.sv
src/rgmii_rx.sv
verif/rgmii_rx_tb.sv

// File: src/ddr_input_buffer.sv
`timescale 1ns/100ps

module ddr_input_buffer #(
    parameter int INPUT_WIDTH = 4
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic [INPUT_WIDTH-1:0]     ddr_input,
    output logic [2*INPUT_WIDTH-1:0]   ddr_output
);

    logic [INPUT_WIDTH-1:0] rise_capture;
    logic [INPUT_WIDTH-1:0] fall_capture;

    ////////////////////////////////////////
    // Capture on both edges
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        rise_capture <= ddr_input;
    end

    // Second half of the DDR cycle
    always_ff @(negedge clock) begin
        fall_capture <= ddr_input;
    end

    ////////////////////////////////////////
    // Retime into the rising edge domain
    ////////////////////////////////////////

    // Rising sample in the low half, falling sample in the high half
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ddr_output <= '0;
        end else begin
            ddr_output <= {fall_capture, rise_capture};
        end
    end

endmodule

// File: src/rgmii_byte_packager.sv
`timescale 1ns/100ps

module rgmii_byte_packager
    import rgmii_rx_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  logic [7:0]   data,
    input  logic [1:0]   control,
    output rx_byte_t     rx_byte,
    output logic         rx_byte_valid,
    output logic         frame_end,
    output logic         frame_error,
    output link_status_t link_status
);

    typedef enum logic [1:0] {
        STATE_SYNC,
        STATE_PREAMBLE,
        STATE_START_OF_FRAME,
        STATE_PACK
    } state_t;

    // Count value when the last preamble octet is seen
    localparam logic [2:0] PREAMBLE_COUNT_LAST = 3'(PREAMBLE_LENGTH - 1);

    state_t       state;
    state_t       state_next;
    logic [2:0]   preamble_count;
    logic [2:0]   preamble_count_next;
    byte_t        data_q;
    logic         rx_dv_q;
    logic         rx_er_q;
    logic         first_pending;
    logic         first_pending_next;
    logic         error_flag;
    logic         error_flag_next;
    logic         byte_valid_next;
    logic         frame_end_next;
    logic         frame_error_next;
    logic         status_nibble_valid;

    ////////////////////////////////////////
    // Input stage and RX_CTL decode
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        data_q <= data;
    end

    // RX_DV on the rising edge, RX_ER folded into the falling edge
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            rx_dv_q <= 1'b0;
            rx_er_q <= 1'b0;
        end else begin
            rx_dv_q <= control[0];
            rx_er_q <= control[0] ^ control[1];
        end
    end

    ////////////////////////////////////////
    // Framing state machine
    ////////////////////////////////////////

    always_comb begin
        state_next          = state;
        preamble_count_next = preamble_count;
        first_pending_next  = first_pending;
        error_flag_next     = error_flag;
        byte_valid_next     = 1'b0;
        frame_end_next      = 1'b0;
        frame_error_next    = frame_error;

        case (state)
            STATE_SYNC: begin
                if (rx_dv_q && data_q == PREAMBLE_BYTE) begin
                    preamble_count_next = 3'd1;
                    state_next          = STATE_PREAMBLE;
                end
            end
            STATE_PREAMBLE: begin
                if (rx_dv_q && data_q == PREAMBLE_BYTE) begin
                    preamble_count_next = preamble_count + 3'd1;
                    if (preamble_count == PREAMBLE_COUNT_LAST) begin
                        state_next = STATE_START_OF_FRAME;
                    end
                end else begin
                    // Short preamble or carrier lost
                    state_next = STATE_SYNC;
                end
            end
            STATE_START_OF_FRAME: begin
                if (rx_dv_q && data_q == SFD_BYTE) begin
                    first_pending_next = 1'b1;
                    error_flag_next    = 1'b0;
                    state_next         = STATE_PACK;
                end else begin
                    state_next = STATE_SYNC;
                end
            end
            STATE_PACK: begin
                if (rx_dv_q) begin
                    byte_valid_next    = 1'b1;
                    first_pending_next = 1'b0;
                    error_flag_next    = error_flag | rx_er_q;
                end else begin
                    frame_end_next   = 1'b1;
                    frame_error_next = error_flag;
                    state_next       = STATE_SYNC;
                end
            end
            default: begin
                state_next = STATE_SYNC;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state          <= STATE_SYNC;
            preamble_count <= '0;
            first_pending  <= 1'b0;
            error_flag     <= 1'b0;
            rx_byte_valid  <= 1'b0;
            frame_end      <= 1'b0;
            frame_error    <= 1'b0;
        end else begin
            state          <= state_next;
            preamble_count <= preamble_count_next;
            first_pending  <= first_pending_next;
            error_flag     <= error_flag_next;
            rx_byte_valid  <= byte_valid_next;
            frame_end      <= frame_end_next;
            frame_error    <= frame_error_next;
        end
    end

    // Byte payload, held between valid strobes
    always_ff @(posedge clock) begin
        if (byte_valid_next) begin
            rx_byte <= '{first: first_pending, data: data_q};
        end
    end

    ////////////////////////////////////////
    // In-band link status
    ////////////////////////////////////////

    // PHY repeats the status nibble on both edges during idle
    assign status_nibble_valid = !rx_dv_q && !rx_er_q && (data_q[3:0] == data_q[7:4]);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            link_status <= '0;
        end else if (status_nibble_valid) begin
            link_status <= '{link_up: data_q[0], speed: data_q[2:1], full_duplex: data_q[3]};
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    // End of frame always lands after the last byte, never with it
    assert property (@(posedge clock) disable iff (!reset_n)
        !(rx_byte_valid && frame_end))
        else $error("rx_byte_valid and frame_end high together");

    assert property (@(posedge clock) disable iff (!reset_n)
        frame_end |=> !frame_end)
        else $error("frame_end longer than one cycle");

endmodule

// File: src/rgmii_rx.sv
`timescale 1ns/100ps

module rgmii_rx
    import rgmii_rx_pkg::*;
(
    input  logic          clock,
    input  logic          reset_n,
    input  logic [3:0]    rxd,
    input  logic          rx_ctl,
    output rx_byte_t      rx_byte,
    output logic          rx_byte_valid,
    output logic          frame_done,
    output frame_status_t frame_status,
    output link_status_t  link_status
);

    logic [7:0] data_word;
    logic [1:0] control_word;
    logic       frame_end;
    logic       frame_error;

    ////////////////////////////////////////
    // DDR capture of RXD and RX_CTL
    ////////////////////////////////////////

    ddr_input_buffer #(
        .INPUT_WIDTH (4)
    ) data_buffer (
        .clock      (clock),
        .reset_n    (reset_n),
        .ddr_input  (rxd),
        .ddr_output (data_word)
    );

    ddr_input_buffer #(
        .INPUT_WIDTH (1)
    ) control_buffer (
        .clock      (clock),
        .reset_n    (reset_n),
        .ddr_input  (rx_ctl),
        .ddr_output (control_word)
    );

    ////////////////////////////////////////
    // Framing and frame check
    ////////////////////////////////////////

    rgmii_byte_packager byte_packager (
        .clock         (clock),
        .reset_n       (reset_n),
        .data          (data_word),
        .control       (control_word),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .frame_end     (frame_end),
        .frame_error   (frame_error),
        .link_status   (link_status)
    );

    rx_crc_checker crc_checker (
        .clock         (clock),
        .reset_n       (reset_n),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .frame_end     (frame_end),
        .frame_error   (frame_error),
        .frame_done    (frame_done),
        .frame_status  (frame_status)
    );

endmodule

// File: src/rgmii_rx_pkg.sv
package rgmii_rx_pkg;

    ////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////

    typedef logic [7:0]  byte_t;

    // 0 is 10 Mb/s, 1 is 100 Mb/s, 2 is 1000 Mb/s
    typedef logic [1:0]  speed_t;

    // Bytes after the delimiter, FCS included
    typedef logic [15:0] frame_length_t;

    ////////////////////////////////////////
    // Grouped signals
    ////////////////////////////////////////

    typedef struct packed {
        logic  first;
        byte_t data;
    } rx_byte_t;

    typedef struct packed {
        logic          crc_ok;
        logic          rx_error;
        frame_length_t length;
    } frame_status_t;

    typedef struct packed {
        logic   link_up;
        speed_t speed;
        logic   full_duplex;
    } link_status_t;

    ////////////////////////////////////////
    // Ethernet framing constants
    ////////////////////////////////////////

    localparam byte_t       PREAMBLE_BYTE   = 8'h55;
    localparam byte_t       SFD_BYTE        = 8'hD5;
    localparam int          PREAMBLE_LENGTH = 7;

    // Register value after data plus a correct FCS
    localparam logic [31:0] CRC_RESIDUE     = 32'hC704DD7B;

endpackage

// File: src/rx_crc_checker.sv
`timescale 1ns/100ps

module rx_crc_checker
    import rgmii_rx_pkg::*;
(
    input  logic          clock,
    input  logic          reset_n,
    input  rx_byte_t      rx_byte,
    input  logic          rx_byte_valid,
    input  logic          frame_end,
    input  logic          frame_error,
    output logic          frame_done,
    output frame_status_t frame_status
);

    localparam logic [31:0] CRC_POLYNOMIAL = 32'h04C11DB7;
    localparam logic [31:0] CRC_INITIAL    = 32'hFFFFFFFF;

    logic [31:0]   crc_register;
    logic [31:0]   crc_seed;
    frame_length_t byte_count;
    frame_length_t byte_count_seed;

    ////////////////////////////////////////
    // CRC-32 byte step
    ////////////////////////////////////////

    // Ethernet sends bit 0 of each octet first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input byte_t value);
        logic [31:0] next_crc;
        logic        feedback;
        next_crc = crc;
        for (int i = 0; i < 8; i++) begin
            feedback = next_crc[31] ^ value[i];
            next_crc = {next_crc[30:0], 1'b0};
            if (feedback) begin
                next_crc = next_crc ^ CRC_POLYNOMIAL;
            end
        end
        return next_crc;
    endfunction

    ////////////////////////////////////////
    // Running CRC and byte count
    ////////////////////////////////////////

    // First byte restarts both accumulators
    assign crc_seed        = rx_byte.first ? CRC_INITIAL : crc_register;
    assign byte_count_seed = rx_byte.first ? frame_length_t'(0) : byte_count;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            crc_register <= CRC_INITIAL;
            byte_count   <= '0;
        end else if (rx_byte_valid) begin
            crc_register <= crc_step(crc_seed, rx_byte.data);
            byte_count   <= byte_count_seed + frame_length_t'(1);
        end
    end

    ////////////////////////////////////////
    // Per-frame status
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            frame_done   <= 1'b0;
            frame_status <= '0;
        end else begin
            frame_done <= frame_end;
            if (frame_end) begin
                frame_status <= '{
                    crc_ok:   (crc_register == CRC_RESIDUE),
                    rx_error: frame_error,
                    length:   byte_count
                };
            end
        end
    end

    // Status is only ever reported for a frame the packager closed
    assert property (@(posedge clock) disable iff (!reset_n)
        frame_done |-> $past(frame_end))
        else $error("frame_done without frame_end one cycle before");

endmodule

// File: verif/rgmii_rx_tb.sv
`timescale 1ns/100ps

module rgmii_rx_tb
    import rgmii_rx_pkg::*;
();

    localparam int CLOCK_HALF_PERIOD = 10;
    localparam int DRIVE_DELAY       = 2;
    localparam int RESET_CYCLES      = 5;
    localparam int GAP_BYTES         = 12;
    localparam int STATUS_LATENCY    = 3;
    // Tests need about 1500 cycles, the rest is margin
    localparam int TIMEOUT_CYCLES    = 4000;

    logic          clock;
    logic          reset_n;
    logic [3:0]    rxd;
    logic          rx_ctl;
    rx_byte_t      rx_byte;
    logic          rx_byte_valid;
    logic          frame_done;
    frame_status_t frame_status;
    link_status_t  link_status;

    integer        seed = 32'hf266a8a7;
    rx_byte_t      byte_queue[$];
    frame_status_t status_queue[$];
    rx_byte_t      expected_byte;
    frame_status_t expected_status;
    int            byte_queue_count;
    int            status_queue_count;
    link_status_t  expected_link;
    logic          link_check;
    logic [3:0]    idle_nibble;
    string         test_name;
    int            error_count;
    int            errors_at_start;
    int            pass_count;
    int            fail_count;
    int            cycle_count;

    rgmii_rx u_dut (
        .clock         (clock),
        .reset_n       (reset_n),
        .rxd           (rxd),
        .rx_ctl        (rx_ctl),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .frame_done    (frame_done),
        .frame_status  (frame_status),
        .link_status   (link_status)
    );

    initial clock = 1'b0;
    always #CLOCK_HALF_PERIOD clock = ~clock;

    ////////////////////////////////////////
    // Reference model helpers
    ////////////////////////////////////////

    // Reflected CRC-32, FCS is the complement
    function automatic logic [31:0] ethernet_fcs(input byte_t data[$]);
        logic [31:0] crc;
        crc = 32'hFFFFFFFF;
        foreach (data[i]) begin
            crc = crc ^ {24'h0, data[i]};
            for (int b = 0; b < 8; b++) begin
                if (crc[0]) begin
                    crc = (crc >> 1) ^ 32'hEDB88320;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        return ~crc;
    endfunction

    function automatic logic [3:0] status_nibble(input link_status_t status);
        return {status.full_duplex, status.speed, status.link_up};
    endfunction

    task automatic refresh_heads();
        byte_queue_count   = byte_queue.size();
        status_queue_count = status_queue.size();
        expected_byte      = (byte_queue_count != 0) ? byte_queue[0] : '0;
        expected_status    = (status_queue_count != 0) ? status_queue[0] : '0;
    endtask

    // Consume expected items as the DUT delivers them
    always @(posedge clock) begin
        if (reset_n && rx_byte_valid && byte_queue.size() != 0) begin
            void'(byte_queue.pop_front());
        end
        if (reset_n && frame_done && status_queue.size() != 0) begin
            void'(status_queue.pop_front());
        end
        refresh_heads();
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    assert property (@(posedge clock) disable iff (!reset_n)
        rx_byte_valid && byte_queue_count != 0 |-> rx_byte == expected_byte)
        else begin
            $display("Error: %s rx_byte expected %h actual %h", test_name,
                     $sampled(expected_byte), $sampled(rx_byte));
            error_count++;
        end

    assert property (@(posedge clock) disable iff (!reset_n)
        rx_byte_valid |-> byte_queue_count != 0)
        else begin
            $display("%s: byte delivered when none was expected", test_name);
            error_count++;
        end

    assert property (@(posedge clock) disable iff (!reset_n)
        frame_done && status_queue_count != 0 |-> frame_status == expected_status)
        else begin
            $display("Error: %s frame_status expected %h actual %h", test_name,
                     $sampled(expected_status), $sampled(frame_status));
            error_count++;
        end

    assert property (@(posedge clock) disable iff (!reset_n)
        frame_done |-> status_queue_count != 0)
        else begin
            $display("%s: frame reported when none was expected", test_name);
            error_count++;
        end

    assert property (@(posedge clock) disable iff (!reset_n)
        link_check |-> link_status == expected_link)
        else begin
            $display("Error: %s link_status expected %h actual %h", test_name,
                     $sampled(expected_link), $sampled(link_status));
            error_count++;
        end

    ////////////////////////////////////////
    // PHY side stimulus
    ////////////////////////////////////////

    // Low nibble and RX_DV settle before the rise, high nibble and DV xor ER after it
    task automatic send_byte(input byte_t value, input logic dv, input logic er);
        @(negedge clock);
        #DRIVE_DELAY;
        rxd    = value[3:0];
        rx_ctl = dv;
        @(posedge clock);
        #DRIVE_DELAY;
        rxd    = value[7:4];
        rx_ctl = dv ^ er;
    endtask

    task automatic send_idle(input int count);
        repeat (count) send_byte({idle_nibble, idle_nibble}, 1'b0, 1'b0);
    endtask

    task automatic send_frame(input int preamble_octets, input byte_t delimiter,
                              input bit corrupt, input bit inject_error,
                              input bit expect_frame);
        byte_t         frame_bytes[$];
        int            payload_length;
        int            flip_bit;
        int            error_index;
        logic [31:0]   fcs;
        frame_status_t status;
        rx_byte_t      expected_entry;
        payload_length = 46 + ($unsigned($random(seed)) % 55);
        for (int i = 0; i < payload_length; i++) begin
            frame_bytes.push_back(byte_t'($random(seed)));
        end
        fcs = ethernet_fcs(frame_bytes);
        for (int i = 0; i < 4; i++) begin
            frame_bytes.push_back(fcs[8*i +: 8]);
        end
        if (corrupt) begin
            flip_bit = $unsigned($random(seed)) % (payload_length * 8);
            frame_bytes[flip_bit / 8] = frame_bytes[flip_bit / 8] ^ byte_t'(1 << (flip_bit % 8));
        end
        error_index = inject_error ? ($unsigned($random(seed)) % payload_length) : -1;
        if (expect_frame) begin
            foreach (frame_bytes[i]) begin
                expected_entry.first = (i == 0);
                expected_entry.data  = frame_bytes[i];
                byte_queue.push_back(expected_entry);
            end
            status = '{crc_ok: !corrupt, rx_error: inject_error,
                       length: frame_length_t'(payload_length + 4)};
            status_queue.push_back(status);
            refresh_heads();
        end
        repeat (preamble_octets) send_byte(PREAMBLE_BYTE, 1'b1, 1'b0);
        send_byte(delimiter, 1'b1, 1'b0);
        foreach (frame_bytes[i]) begin
            send_byte(frame_bytes[i], 1'b1, i == error_index);
        end
        send_idle(GAP_BYTES);
    endtask

    task automatic check_link_status(input link_status_t status);
        link_check  = 1'b0;
        idle_nibble = status_nibble(status);
        // Let the new nibble pass the pipeline before checking
        send_idle(STATUS_LATENCY + 1);
        expected_link = status;
        link_check    = 1'b1;
        send_idle(8);
    endtask

    ////////////////////////////////////////
    // Test bookkeeping
    ////////////////////////////////////////

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        while (byte_queue.size() != 0 || status_queue.size() != 0) begin
            @(posedge clock);
        end
        // Let the checks of the last edge report
        @(negedge clock);
        if (error_count == errors_at_start) begin
            pass_count++;
            $display("%-16s pass", test_name);
        end else begin
            fail_count++;
            $display("%-16s FAIL (%0d errors)", test_name, error_count - errors_at_start);
        end
    endtask

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: run stopped after %0d cycles", cycle_count);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset_n       = 1'b0;
        rxd           = 4'h0;
        rx_ctl        = 1'b0;
        idle_nibble   = 4'h0;
        link_check    = 1'b0;
        expected_link = '0;
        test_name     = "reset";
        error_count   = 0;
        pass_count    = 0;
        fail_count    = 0;
        refresh_heads();
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset_n = 1'b1;

        start_test("reset");
        link_check = 1'b1;
        send_idle(20);
        finish_test();

        start_test("good_frames");
        send_frame(PREAMBLE_LENGTH, SFD_BYTE, 1'b0, 1'b0, 1'b1);
        send_frame(PREAMBLE_LENGTH, SFD_BYTE, 1'b0, 1'b0, 1'b1);
        finish_test();

        start_test("corrupted_fcs");
        send_frame(PREAMBLE_LENGTH, SFD_BYTE, 1'b1, 1'b0, 1'b1);
        finish_test();

        start_test("rx_er_in_frame");
        send_frame(PREAMBLE_LENGTH, SFD_BYTE, 1'b0, 1'b1, 1'b1);
        finish_test();

        // Each fault is followed by a good frame
        start_test("short_preamble");
        send_frame(PREAMBLE_LENGTH - 1, SFD_BYTE, 1'b0, 1'b0, 1'b0);
        send_frame(PREAMBLE_LENGTH, SFD_BYTE, 1'b0, 1'b0, 1'b1);
        finish_test();

        start_test("long_preamble");
        send_frame(PREAMBLE_LENGTH + 1, SFD_BYTE, 1'b0, 1'b0, 1'b0);
        send_frame(PREAMBLE_LENGTH, SFD_BYTE, 1'b0, 1'b0, 1'b1);
        finish_test();

        start_test("bad_delimiter");
        send_frame(PREAMBLE_LENGTH, 8'hD4, 1'b0, 1'b0, 1'b0);
        send_frame(PREAMBLE_LENGTH, SFD_BYTE, 1'b0, 1'b0, 1'b1);
        finish_test();

        start_test("inband_status");
        check_link_status('{link_up: 1'b1, speed: 2'd2, full_duplex: 1'b1});
        check_link_status('{link_up: 1'b1, speed: 2'd1, full_duplex: 1'b0});
        finish_test();

        $display("Summary: %0d pass, %0d fail", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
